/* swin_pkg.sv */
package swin_pkg;

   // ----------------------------------------
   // widths
   localparam int PIX_W       = 8;
   localparam int BEAT_PIX    = 16;
   localparam int BANK_PIX    = 8;
   localparam int NUM_BANKS   = 3;
   localparam int NUM_GROUPS  = 3;
   localparam int GROUP_PIX   = BANK_PIX * NUM_BANKS;  // 24 pixels per group word
   localparam int CONF_ADDR_W = 9;
   localparam int CONF_W      = 19;
   localparam int CYCLE_W     = 8;
   localparam int OFFSET_W    = 3;
   localparam int SPLIT_W     = CONF_W - 1 - CYCLE_W - NUM_BANKS - OFFSET_W;
   localparam int ROT_W       = 2;  // bank rotation 0..2

   // taps of the ctl delay line in the read path
   localparam int DEROT_TAP = 3;
   localparam int DEOFF_TAP = 4;
   localparam int SEL_TAP   = 5;
   localparam int LA_DLY    = SEL_TAP + 1;

   // ----------------------------------------
   // types
   typedef logic [BEAT_PIX*PIX_W-1:0]  pix_beat_t;
   typedef logic [GROUP_PIX*PIX_W-1:0] group_word_t;
   typedef logic [GROUP_PIX-1:0]       group_mask_t;

   typedef enum logic [NUM_GROUPS-1:0] {
      GRP_0 = 3'b001,
      GRP_1 = 3'b010,
      GRP_2 = 3'b100
   } grp_t;

   // one-cold bank pattern, the cold bit marks the top bank after rotation
   typedef enum logic [NUM_BANKS-1:0] {
      SHUF_NONE = 3'b011,
      SHUF_ONE  = 3'b101,
      SHUF_TWO  = 3'b110
   } shuf_t;

   typedef struct packed {
      logic [SPLIT_W-1:0]   split;     // unused
      logic                 addr_ret;
      logic [CYCLE_W-1:0]   cycle;
      logic [NUM_BANKS-1:0] order;
      logic [OFFSET_W-1:0]  offset;
   } conf_entry_t;

   typedef struct packed {
      logic                vld;
      logic [OFFSET_W-1:0] offset;
      shuf_t               shuf;
      grp_t                group;
   } beat_ctl_t;

   typedef struct packed {
      logic [NUM_GROUPS-1:0] group_en;
      logic [NUM_BANKS-1:0]  addr_inc;
      group_mask_t           mask;
      group_word_t           data;
   } bram_wr_t;

   // ----------------------------------------
   // bank rotation helpers
   function automatic logic [ROT_W-1:0] shuf_banks(shuf_t s);
      case (s)
         SHUF_ONE: return 2'd1;
         SHUF_TWO: return 2'd2;
         default:  return 2'd0;
      endcase
   endfunction

   function automatic group_word_t word_rotl(group_word_t w, logic [ROT_W-1:0] n);
      logic [2*GROUP_PIX*PIX_W-1:0] dbl;
      dbl = {w, w} << (n * BANK_PIX * PIX_W);
      return dbl[2*GROUP_PIX*PIX_W-1 -: GROUP_PIX*PIX_W];
   endfunction

   function automatic group_word_t word_rotr(group_word_t w, logic [ROT_W-1:0] n);
      logic [2*GROUP_PIX*PIX_W-1:0] dbl;
      dbl = {w, w} >> (n * BANK_PIX * PIX_W);
      return dbl[GROUP_PIX*PIX_W-1:0];
   endfunction

   function automatic group_mask_t mask_rotl(group_mask_t m, logic [ROT_W-1:0] n);
      logic [2*GROUP_PIX-1:0] dbl;
      dbl = {m, m} << (n * BANK_PIX);
      return dbl[2*GROUP_PIX-1 -: GROUP_PIX];
   endfunction

endpackage

/* conf_sequencer.sv */
`timescale 1ns/1ps

module conf_sequencer import swin_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   pix_vld,
   input  pix_beat_t              pix_data,
   input  conf_entry_t            conf_rd_data,
   output logic [CONF_ADDR_W-1:0] conf_rd_addr,
   output beat_ctl_t              ctl,
   output pix_beat_t              pix_q
);

   logic                vld_q;
   logic [CYCLE_W-1:0]  beat_cnt;   // beats left in the line
   grp_t                grp_q;
   shuf_t               shuf_q;
   logic [OFFSET_W-1:0] offset_q;
   logic                line_start;

   assign line_start = pix_vld && (beat_cnt == '0);

   // ----------------------------------------
   // line state

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_q        <= 1'b0;
         beat_cnt     <= '0;
         grp_q        <= GRP_2;  // first line lands in GRP_0
         shuf_q       <= SHUF_NONE;
         offset_q     <= '0;
         conf_rd_addr <= '0;
      end else begin
         vld_q <= pix_vld;
         if (line_start) begin
            beat_cnt <= conf_rd_data.cycle;
            grp_q    <= grp_t'({grp_q[NUM_GROUPS-2:0], grp_q[NUM_GROUPS-1]});
            shuf_q   <= shuf_t'(conf_rd_data.order);
            offset_q <= conf_rd_data.offset;
            // next entry is fetched while this line runs
            if (conf_rd_data.addr_ret)
               conf_rd_addr <= '0;
            else
               conf_rd_addr <= conf_rd_addr + 1'b1;
         end else if (pix_vld) begin
            beat_cnt <= beat_cnt - 1'b1;
            shuf_q   <= shuf_t'({shuf_q[0], shuf_q[NUM_BANKS-1:1]});  // rotate right
         end
      end
   end

   // beat payload
   always_ff @(posedge clk) begin
      if (pix_vld)
         pix_q <= pix_data;
   end

   assign ctl = '{
      vld:    vld_q,
      offset: offset_q,
      shuf:   shuf_q,
      group:  grp_q
   };

   // ----------------------------------------
   // checks

   // a zero cycle would leave no time for the next entry to come back
   a_cycle_nonzero : assert property (
      @(posedge clk) disable iff (!rst_n)
      line_start |-> (conf_rd_data.cycle != '0)
   );

   // the order field of every entry must be a legal one-cold pattern
   a_shuf_legal : assert property (
      @(posedge clk) disable iff (!rst_n)
      shuf_q inside {SHUF_NONE, SHUF_ONE, SHUF_TWO}
   );

endmodule

/* write_aligner.sv */
`timescale 1ns/1ps

module write_aligner import swin_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  beat_ctl_t ctl,
   input  pix_beat_t pix_q,
   output bram_wr_t  bram_wr,
   output grp_t      rd_group_sel
);

   // decode stage
   logic [NUM_GROUPS-1:0] grp_en_a;
   logic [NUM_BANKS-1:0]  inc_a;
   logic [ROT_W-1:0]      banks_a;
   logic [OFFSET_W-1:0]   offset_a;
   pix_beat_t             pix_a;

   // offset stage
   logic [NUM_GROUPS-1:0] grp_en_b;
   logic [NUM_BANKS-1:0]  inc_b;
   logic [ROT_W-1:0]      banks_b;
   group_word_t           word_b;
   group_mask_t           mask_b;

   // rotate / steer stage
   logic [NUM_GROUPS-1:0] grp_en_c;
   logic [NUM_BANKS-1:0]  inc_c;
   group_word_t           word_c;
   group_mask_t           mask_c;

   // ----------------------------------------
   // control pipe

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         grp_en_a <= '0;
         inc_a    <= '0;
         grp_en_b <= '0;
         inc_b    <= '0;
         grp_en_c <= '0;
         inc_c    <= '0;
      end else begin
         grp_en_a <= ctl.vld ? ctl.group : '0;  // no write on idle cycles
         inc_a    <= ctl.vld ? ctl.shuf : '0;
         grp_en_b <= grp_en_a;
         inc_b    <= inc_a;
         grp_en_c <= grp_en_b;
         inc_c    <= inc_b;
      end
   end

   // ----------------------------------------
   // data pipe

   always_ff @(posedge clk) begin
      banks_a  <= shuf_banks(ctl.shuf);
      offset_a <= ctl.offset;
      pix_a    <= pix_q;

      // place beat at pixels offset..offset+15
      word_b  <= group_word_t'(pix_a) << (offset_a * PIX_W);
      mask_b  <= group_mask_t'({BEAT_PIX{1'b1}}) << offset_a;
      banks_b <= banks_a;

      // bank rotation toward the top
      word_c <= word_rotl(word_b, banks_b);
      mask_c <= mask_rotl(mask_b, banks_b);
   end

   assign bram_wr = '{
      group_en: grp_en_c,
      addr_inc: inc_c,
      mask:     mask_c,
      data:     word_c
   };

   assign rd_group_sel = grp_t'(grp_en_c);  // read the group being written

   // ----------------------------------------
   // checks

   // the group rotation upstream must never hit two groups at once
   a_group_en_onehot0 : assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(bram_wr.group_en)
   );

endmodule

/* line_assembler.sv */
`timescale 1ns/1ps

module line_assembler import swin_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  beat_ctl_t   ctl,
   input  pix_beat_t   pix_q,
   input  group_word_t rd_data_gp0,
   input  group_word_t rd_data_gp1,
   input  group_word_t rd_data_gp2,
   output pix_beat_t   line_0,
   output pix_beat_t   line_1,
   output pix_beat_t   line_2,
   output logic        line_vld
);

   beat_ctl_t   ctl_d [LA_DLY];
   pix_beat_t   pix_d [LA_DLY];
   group_word_t rd_word [NUM_GROUPS];
   group_word_t derot [NUM_GROUPS];
   pix_beat_t   deoff [NUM_GROUPS];

   assign rd_word[0] = rd_data_gp0;
   assign rd_word[1] = rd_data_gp1;
   assign rd_word[2] = rd_data_gp2;

   // ----------------------------------------
   // delay lines to meet the read data

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < LA_DLY; i++)
            ctl_d[i] <= '0;
      end else begin
         ctl_d[0] <= ctl;
         for (int i = 1; i < LA_DLY; i++)
            ctl_d[i] <= ctl_d[i-1];
      end
   end

   always_ff @(posedge clk) begin
      pix_d[0] <= pix_q;
      for (int i = 1; i < LA_DLY; i++)
         pix_d[i] <= pix_d[i-1];
   end

   // ----------------------------------------
   // undo rotation, then offset

   always_ff @(posedge clk) begin
      for (int g = 0; g < NUM_GROUPS; g++) begin
         derot[g] <= word_rotr(rd_word[g], shuf_banks(ctl_d[DEROT_TAP].shuf));
         deoff[g] <= derot[g][ctl_d[DEOFF_TAP].offset*PIX_W +: BEAT_PIX*PIX_W];
      end
   end

   // ----------------------------------------
   // line select
   // the two groups not being written hold the older lines

   always_ff @(posedge clk) begin
      line_2 <= pix_d[SEL_TAP];  // live line
      case (ctl_d[SEL_TAP].group)
         GRP_0: begin
            line_0 <= deoff[1];
            line_1 <= deoff[2];
         end
         GRP_1: begin
            line_0 <= deoff[2];
            line_1 <= deoff[0];
         end
         default: begin  // GRP_2
            line_0 <= deoff[0];
            line_1 <= deoff[1];
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         line_vld <= 1'b0;
      else
         line_vld <= ctl_d[SEL_TAP].vld;
   end

endmodule

/* swin_decoder.sv */
`timescale 1ns/1ps

module swin_decoder import swin_pkg::*; (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   pix_vld,
   input  pix_beat_t              pix_data,
   input  conf_entry_t            conf_rd_data,
   output logic [CONF_ADDR_W-1:0] conf_rd_addr,
   output bram_wr_t               bram_wr,
   output grp_t                   rd_group_sel,
   input  group_word_t            rd_data_gp0,
   input  group_word_t            rd_data_gp1,
   input  group_word_t            rd_data_gp2,
   output pix_beat_t              line_0,
   output pix_beat_t              line_1,
   output pix_beat_t              line_2,
   output logic                   line_vld
);

   beat_ctl_t ctl;
   pix_beat_t pix_q;

   // config fetch and per-beat control
   conf_sequencer conf_sequencer_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .pix_vld      (pix_vld),
      .pix_data     (pix_data),
      .conf_rd_data (conf_rd_data),
      .conf_rd_addr (conf_rd_addr),
      .ctl          (ctl),
      .pix_q        (pix_q)
   );

   // write side of the line buffer
   write_aligner write_aligner_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .ctl          (ctl),
      .pix_q        (pix_q),
      .bram_wr      (bram_wr),
      .rd_group_sel (rd_group_sel)
   );

   // read side, three window lines
   line_assembler line_assembler_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .ctl         (ctl),
      .pix_q       (pix_q),
      .rd_data_gp0 (rd_data_gp0),
      .rd_data_gp1 (rd_data_gp1),
      .rd_data_gp2 (rd_data_gp2),
      .line_0      (line_0),
      .line_1      (line_1),
      .line_2      (line_2),
      .line_vld    (line_vld)
   );

endmodule

/* tb_swin_decoder.sv */
`timescale 1ns/1ps

module tb_swin_decoder import swin_pkg::*; ();

   localparam int NUM_BEATS = 200;
   localparam int NUM_TESTS = 5;
   localparam int DEPTH     = 8;   // beat t sits in stage k after edge t+k
   localparam int DRAIN_MAX = 40;

   logic                   clk = 1'b0;
   logic                   rst_n;
   logic                   rst_chk;  // reset window still being checked
   logic                   pix_vld;
   logic                   line_vld;
   pix_beat_t              pix_data, line_0, line_1, line_2;
   conf_entry_t            conf_rd_data;
   logic [CONF_ADDR_W-1:0] conf_rd_addr, addr_lat, m_addr;
   bram_wr_t               bram_wr;
   grp_t                   rd_group_sel;
   group_word_t            rd_data_gp0, rd_data_gp1, rd_data_gp2;
   logic [2:0]             sel_prev;

   conf_entry_t rom [4];
   integer      seed;
   int          n_chk [NUM_TESTS];
   int          n_fail [NUM_TESTS];
   int          n_beats, n_lines, n_bad, tot_chk, tot_fail;
   bit          drained;
   string       test_name [NUM_TESTS] = '{"reset", "conf sequencing", "write alignment",
                                         "address increment", "line output"};

   // reference model, one entry per pipeline stage
   logic [CYCLE_W-1:0] m_cnt;
   logic [2:0]         m_grp, m_shuf, m_off;
   conf_entry_t        ent;
   bit                 p_vld [DEPTH];
   logic [2:0]         p_grp [DEPTH];
   logic [2:0]         p_shuf [DEPTH];
   logic [2:0]         p_off [DEPTH];
   pix_beat_t          p_pix [DEPTH];
   pix_beat_t          l0 [DEPTH];
   pix_beat_t          l1 [DEPTH];

   always #20 clk = ~clk;

   swin_decoder swin_decoder_i (.*);

   // ----------------------------------------
   // model helpers

   // cold bit 2, 1, 0 gives 0, 1, 2 banks
   function automatic int rot_of(logic [2:0] s);
      int r;
      r = 0;
      for (int i = 0; i < 3; i++)
         if (!s[i])
            r = 2 - i;
      return r;
   endfunction

   // where line pixel p lives inside the stored group word
   function automatic int phys_pix(logic [2:0] off, logic [2:0] shuf, int p);
      return (int'(off) + p + BANK_PIX * rot_of(shuf)) % GROUP_PIX;
   endfunction

   function automatic group_word_t place_word(pix_beat_t pix, logic [2:0] off, logic [2:0] shuf);
      group_word_t w;
      w = '0;
      for (int p = 0; p < BEAT_PIX; p++)
         w[phys_pix(off, shuf, p)*PIX_W +: PIX_W] = pix[p*PIX_W +: PIX_W];
      return w;
   endfunction

   function automatic group_mask_t place_mask(logic [2:0] off, logic [2:0] shuf);
      group_mask_t m;
      m = '0;
      for (int p = 0; p < BEAT_PIX; p++)
         m[phys_pix(off, shuf, p)] = 1'b1;
      return m;
   endfunction

   function automatic pix_beat_t extract_line(group_word_t w, logic [2:0] off, logic [2:0] shuf);
      pix_beat_t l;
      for (int p = 0; p < BEAT_PIX; p++)
         l[p*PIX_W +: PIX_W] = w[phys_pix(off, shuf, p)*PIX_W +: PIX_W];
      return l;
   endfunction

   // which = 0 for line_0, 1 for line_1; the groups after the written one
   function automatic group_word_t older_word(logic [2:0] grp, int which);
      int src;
      src = grp[0] ? 1 : (grp[1] ? 2 : 0);
      src = (src + which) % NUM_GROUPS;
      return src == 0 ? rd_data_gp0 : (src == 1 ? rd_data_gp1 : rd_data_gp2);
   endfunction

   task automatic rand_word(output group_word_t w);
      for (int i = 0; i < GROUP_PIX*PIX_W/32; i++)
         w[i*32 +: 32] = $random(seed);
   endtask

   task automatic log_mismatch(int k, string what, group_word_t exp, group_word_t act);
      n_fail[k]++;
      $display("FAIL %s: %s expected %0h actual %0h at %0t",
               test_name[k], what, exp, act, $time);
   endtask

   task automatic wait_drain(output bit ok);
      int n;
      n = 0;
      while (n_lines != n_beats && n < DRAIN_MAX) begin
         @(negedge clk);
         n++;
      end
      ok = (n_lines == n_beats);
   endtask

   // ----------------------------------------
   // config ROM (one cycle latency) and line-buffer read ports
   always @(negedge clk) begin
      conf_rd_data = rom[addr_lat[1:0]];
      addr_lat = conf_rd_addr;
      if (sel_prev != 3'b000) begin  // BRAM answers one cycle after the select
         rand_word(rd_data_gp0);
         rand_word(rd_data_gp1);
         rand_word(rd_data_gp2);
      end
      sel_prev = rd_group_sel;
   end

   always @(posedge clk) begin
      if (!rst_n) begin
         m_cnt = '0;
         m_grp = GRP_2;
         m_shuf = SHUF_NONE;
         m_off = '0;
         m_addr = '0;
         for (int i = 0; i < DEPTH; i++)
            p_vld[i] = 1'b0;
      end else begin
         for (int i = DEPTH-1; i > 0; i--) begin
            p_vld[i] = p_vld[i-1];
            p_grp[i] = p_grp[i-1];
            p_shuf[i] = p_shuf[i-1];
            p_off[i] = p_off[i-1];
            p_pix[i] = p_pix[i-1];
            l0[i] = l0[i-1];
            l1[i] = l1[i-1];
         end
         // stage 5 meets the words now on the read ports
         l0[5] = extract_line(older_word(p_grp[5], 0), p_off[5], p_shuf[5]);
         l1[5] = extract_line(older_word(p_grp[5], 1), p_off[5], p_shuf[5]);
         if (pix_vld) begin
            if (m_cnt == '0) begin  // line start
               ent = rom[m_addr[1:0]];
               m_cnt = ent.cycle;
               m_grp = {m_grp[1:0], m_grp[2]};
               m_shuf = ent.order;
               m_off = ent.offset;
               m_addr = ent.addr_ret ? '0 : m_addr + 1'b1;
            end else begin
               m_cnt = m_cnt - 1'b1;
               m_shuf = {m_shuf[0], m_shuf[2:1]};
            end
         end
         p_vld[0] = pix_vld;
         p_grp[0] = m_grp;
         p_shuf[0] = m_shuf;
         p_off[0] = m_off;
         p_pix[0] = pix_data;
      end
   end

   // ----------------------------------------
   // checks on the falling edge, outputs settled
   a_reset_idle : assert property (@(negedge clk)
      rst_chk |-> {bram_wr.group_en, rd_group_sel, line_vld, conf_rd_addr} == '0)
      else log_mismatch(0, "reset outputs", '0,
                        {bram_wr.group_en, rd_group_sel, line_vld, conf_rd_addr});
   a_conf_addr : assert property (@(negedge clk) disable iff (!rst_n)
      conf_rd_addr == m_addr)
      else log_mismatch(1, "conf address", m_addr, conf_rd_addr);
   a_group_en : assert property (@(negedge clk) disable iff (!rst_n)
      bram_wr.group_en == (p_vld[3] ? p_grp[3] : 3'b000))
      else log_mismatch(1, "group enable", p_vld[3] ? p_grp[3] : 3'b000, bram_wr.group_en);
   a_rd_sel : assert property (@(negedge clk) disable iff (!rst_n)
      rd_group_sel == (p_vld[3] ? p_grp[3] : 3'b000))
      else log_mismatch(1, "read group select", p_vld[3] ? p_grp[3] : 3'b000, rd_group_sel);
   a_wr_data : assert property (@(negedge clk) disable iff (!rst_n)
      p_vld[3] |-> bram_wr.data == place_word(p_pix[3], p_off[3], p_shuf[3]))
      else log_mismatch(2, "write data", place_word(p_pix[3], p_off[3], p_shuf[3]),
                        bram_wr.data);
   a_wr_mask : assert property (@(negedge clk) disable iff (!rst_n)
      p_vld[3] |-> bram_wr.mask == place_mask(p_off[3], p_shuf[3]))
      else log_mismatch(2, "write mask", place_mask(p_off[3], p_shuf[3]), bram_wr.mask);
   a_addr_inc : assert property (@(negedge clk) disable iff (!rst_n)
      p_vld[3] |-> bram_wr.addr_inc == p_shuf[3])
      else log_mismatch(3, "address increment", p_shuf[3], bram_wr.addr_inc);
   a_line_vld : assert property (@(negedge clk) disable iff (!rst_n)
      line_vld == p_vld[7])
      else log_mismatch(4, "line valid", p_vld[7], line_vld);
   a_line_2 : assert property (@(negedge clk) disable iff (!rst_n)
      p_vld[7] |-> line_2 == p_pix[7])
      else log_mismatch(4, "line 2", p_pix[7], line_2);
   a_line_0 : assert property (@(negedge clk) disable iff (!rst_n)
      p_vld[7] |-> line_0 == l0[7])
      else log_mismatch(4, "line 0", l0[7], line_0);
   a_line_1 : assert property (@(negedge clk) disable iff (!rst_n)
      p_vld[7] |-> line_1 == l1[7])
      else log_mismatch(4, "line 1", l1[7], line_1);

   always @(negedge clk) begin
      if (line_vld)
         n_lines++;
      if (rst_chk)
         n_chk[0]++;
      if (rst_n) begin
         n_chk[1] += 3;
         n_chk[4]++;
         if (p_vld[3]) begin
            n_chk[2] += 2;
            n_chk[3]++;
         end
         if (p_vld[7])
            n_chk[4] += 3;
      end
   end

   // ----------------------------------------
   // stimulus and report
   initial begin
      seed = 32'hd505_daca;
      // split set on some entries, nothing reads it
      rom[0] = '{split: 4'h0, addr_ret: 1'b0, cycle: 8'd3, order: SHUF_ONE,  offset: 3'd5};
      rom[1] = '{split: 4'ha, addr_ret: 1'b0, cycle: 8'd1, order: SHUF_TWO,  offset: 3'd0};
      rom[2] = '{split: 4'h0, addr_ret: 1'b0, cycle: 8'd6, order: SHUF_NONE, offset: 3'd7};
      rom[3] = '{split: 4'h5, addr_ret: 1'b1, cycle: 8'd2, order: SHUF_TWO,  offset: 3'd2};
      rst_n = 1'b0;
      rst_chk = 1'b1;
      pix_vld = 1'b0;
      pix_data = '0;
      conf_rd_data = rom[0];
      rd_data_gp0 = '0;
      rd_data_gp1 = '0;
      rd_data_gp2 = '0;
      addr_lat = '0;
      sel_prev = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      repeat (3) @(negedge clk);
      rst_chk = 1'b0;
      for (int i = 0; i < 4*NUM_BEATS && n_beats < NUM_BEATS; i++) begin
         @(negedge clk);
         pix_vld = ($random(seed) & 3) != 0;  // roughly one gap in four
         if (pix_vld) begin
            pix_data = {$random(seed), $random(seed), $random(seed), $random(seed)};
            n_beats++;
         end
      end
      @(negedge clk);
      pix_vld = 1'b0;
      wait_drain(drained);
      repeat (2) @(negedge clk);
      if (!drained) begin
         $display("timeout: %0d beats sent but only %0d lines came out", n_beats, n_lines);
         n_bad++;
      end
      for (int k = 0; k < NUM_TESTS; k++) begin
         if (n_chk[k] == 0) begin
            $display("%s: no check was reached", test_name[k]);
            n_bad++;
         end else begin
            $display("%s: %0d checks, %0d failed", test_name[k], n_chk[k], n_fail[k]);
         end
         tot_chk += n_chk[k];
         tot_fail += n_fail[k];
      end
      $display("%0d checks run, %0d passed, %0d failed, %0d other errors",
               tot_chk, tot_chk - tot_fail, tot_fail, n_bad);
      if (tot_fail == 0 && n_bad == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

/* swin_decoder.f */
swin_pkg.sv
conf_sequencer.sv
write_aligner.sv
line_assembler.sv
swin_decoder.sv
tb_swin_decoder.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_swin_decoder -f swin_decoder.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_swin_decoder)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
   exit 0
fi
exit 1
